/* src/dbg_pkg.sv */
// debug port package: width typedefs, command and request codes, select codes, reply frames
package dbg_pkg;

   // widths that carry a meaning
   typedef logic [31:0] frame_t;
   typedef logic [31:0] word_t;
   typedef logic [5:0]  cmd_t;
   typedef logic [8:0]  req_type_t;
   typedef logic [5:0]  sel_t;
   typedef logic [8:0]  iaddr_t;
   typedef logic [15:0] half_t;

   // command codes, frame bits 31..26
   localparam cmd_t CMD_START     = 6'b000001;
   localparam cmd_t CMD_RESET     = 6'b000010;
   localparam cmd_t CMD_REQ_DATA  = 6'b000011;
   localparam cmd_t CMD_LOAD_LSB  = 6'b000100;
   localparam cmd_t CMD_LOAD_MSB  = 6'b000101;
   localparam cmd_t CMD_MODE_GET  = 6'b001000;
   localparam cmd_t CMD_MODE_CONT = 6'b001001;
   localparam cmd_t CMD_MODE_STEP = 6'b001010;
   localparam cmd_t CMD_STEP      = 6'b100000;
   localparam cmd_t CMD_GOT_DATA  = 6'b100100;
   localparam cmd_t CMD_GIB_DATA  = 6'b100101;

   // request types, address/type bits 8..0
   localparam req_type_t REQ_MEM_DATA     = 9'b000000001;
   localparam req_type_t REQ_MEM_INSTR    = 9'b000000010;
   localparam req_type_t REQ_REG          = 9'b000000100;
   localparam req_type_t REQ_REG_PC       = 9'b000000101;
   localparam req_type_t REQ_FETCH_DATA   = 9'b000001000;
   localparam req_type_t REQ_FETCH_CTRL   = 9'b000001001;
   localparam req_type_t REQ_DECO_DATA    = 9'b000010000;
   localparam req_type_t REQ_DECO_CTRL    = 9'b000010001;
   localparam req_type_t REQ_EXEC_DATA    = 9'b000100000;
   localparam req_type_t REQ_EXEC_CTRL    = 9'b000100001;
   localparam req_type_t REQ_MEM_LAT_DATA = 9'b001000000;
   localparam req_type_t REQ_MEM_LAT_CTRL = 9'b001000001;

   // request selects, 0..31 are registers
   localparam sel_t SEL_MEM_DATA     = 6'b100000;
   localparam sel_t SEL_MEM_INSTR    = 6'b100001;
   localparam sel_t SEL_PC           = 6'b100010;
   localparam sel_t SEL_FETCH_DATA   = 6'b100100;
   localparam sel_t SEL_FETCH_CTRL   = 6'b100101;
   localparam sel_t SEL_DECO_DATA    = 6'b100110;
   localparam sel_t SEL_DECO_CTRL    = 6'b100111;
   localparam sel_t SEL_EXEC_DATA    = 6'b101000;
   localparam sel_t SEL_EXEC_CTRL    = 6'b101001;
   localparam sel_t SEL_MEM_LAT_DATA = 6'b101010;
   localparam sel_t SEL_MEM_LAT_CTRL = 6'b101011;
   localparam sel_t SEL_NONE         = 6'b111111;

   // reply frames
   localparam frame_t FRAME_OK        = {6'b000011, 26'd0};
   localparam frame_t FRAME_NOK       = {6'b000010, 26'd0};
   localparam frame_t FRAME_EOP       = {6'b000100, 26'd0};
   localparam frame_t FRAME_IDLE      = {32{1'b1}};
   localparam frame_t FRAME_MODE_CONT = {CMD_MODE_CONT, 26'd0};
   localparam frame_t FRAME_MODE_STEP = {CMD_MODE_STEP, 26'd0};

   // reply buffer and burst counters
   localparam int NB_WORD_CNT = 2;
   typedef logic [NB_WORD_CNT-1:0] cnt_t;
   localparam cnt_t BUF_WORDS = 2'd3;

   // target sizes
   localparam int IMEM_DEPTH = 512;
   localparam int NB_REGS    = 32;
   localparam int NB_STAGES  = 4;

endpackage

/* src/instr_mem.sv */
// instruction memory: 512 words, byte-lane writes, asynchronous read
`timescale 1ns/1ps

module instr_mem (
   input  logic            i_clock,
   input  logic [3:0]      i_we,
   input  dbg_pkg::iaddr_t i_waddr,
   input  dbg_pkg::word_t  i_wdata,
   input  dbg_pkg::iaddr_t i_raddr,
   output dbg_pkg::word_t  o_rdata
);

   dbg_pkg::word_t mem [dbg_pkg::IMEM_DEPTH];

   // one enable per byte lane
   always_ff @(posedge i_clock) begin
      for (int lane = 0; lane < 4; lane++) begin
         if (i_we[lane]) begin
            mem[i_waddr][lane*8 +: 8] <= i_wdata[lane*8 +: 8];
         end
      end
   end

   assign o_rdata = mem[i_raddr];

endmodule

/* src/target_core.sv */
// minimal target: PC, fetch latch, stand-in pipeline latches, register file
`timescale 1ns/1ps

module target_core (
   input  logic            i_clock,
   input  logic            i_reset,
   input  logic            i_target_reset,
   input  logic            i_valid,
   input  dbg_pkg::word_t  i_instr,
   input  logic [4:0]      i_reg_sel,
   output dbg_pkg::iaddr_t o_fetch_addr,
   output dbg_pkg::word_t  o_pc,
   output logic            o_eop,
   output dbg_pkg::word_t  o_latch_data [dbg_pkg::NB_STAGES],
   output dbg_pkg::word_t  o_latch_ctrl [dbg_pkg::NB_STAGES],
   output dbg_pkg::word_t  o_reg_rdata
);

   dbg_pkg::word_t pc;
   dbg_pkg::word_t latch_data [dbg_pkg::NB_STAGES];
   dbg_pkg::word_t latch_ctrl [dbg_pkg::NB_STAGES];
   dbg_pkg::word_t regs [dbg_pkg::NB_REGS];
   logic           clear;

   assign clear = i_reset | i_target_reset;

   // stage 0 is fetch, later stages just shift it down
   always_ff @(posedge i_clock) begin
      if (clear) begin
         pc <= '0;
         for (int s = 0; s < dbg_pkg::NB_STAGES; s++) begin
            latch_data[s] <= '0;
            latch_ctrl[s] <= '0;
         end
      end else if (i_valid) begin
         pc            <= pc + 32'd1;
         latch_data[0] <= i_instr;
         latch_ctrl[0] <= pc;
         for (int s = 1; s < dbg_pkg::NB_STAGES; s++) begin
            latch_data[s] <= latch_data[s-1];
            latch_ctrl[s] <= latch_ctrl[s-1];
         end
      end
   end

   // register file records what was fetched
   always_ff @(posedge i_clock) begin
      if (i_valid && !clear) begin
         regs[pc[4:0]] <= i_instr;
      end
   end

   assign o_fetch_addr = pc[8:0];
   assign o_pc         = pc;
   assign o_latch_data = latch_data;
   assign o_latch_ctrl = latch_ctrl;
   assign o_reg_rdata  = regs[i_reg_sel];

   // all-ones instruction marks end of program
   assign o_eop = &latch_data[0];

endmodule

/* src/readback_streamer.sv */
// readback streamer: select to word burst, closed by a one-cycle end-of-data
`timescale 1ns/1ps

module readback_streamer (
   input  logic            i_clock,
   input  logic            i_reset,
   input  dbg_pkg::sel_t   i_request_select,
   input  dbg_pkg::half_t  i_mem_addr,
   input  dbg_pkg::word_t  i_pc,
   input  dbg_pkg::word_t  i_reg_rdata,
   input  dbg_pkg::word_t  i_imem_rdata,
   input  dbg_pkg::word_t  i_latch_data [dbg_pkg::NB_STAGES],
   input  dbg_pkg::word_t  i_latch_ctrl [dbg_pkg::NB_STAGES],
   output logic [4:0]      o_reg_sel,
   output dbg_pkg::iaddr_t o_imem_addr,
   output dbg_pkg::word_t  o_word,
   output logic            o_eod
);

   typedef enum logic [1:0] {IDLE, SEND, DONE} stream_state_t;

   stream_state_t   state;
   dbg_pkg::sel_t   sel_q;
   dbg_pkg::iaddr_t addr_q;
   dbg_pkg::cnt_t   word_cnt;
   dbg_pkg::cnt_t   last_word;
   dbg_pkg::sel_t   sel_offset;
   logic            is_latch;
   logic [1:0]      stage;
   logic            pick_ctrl;
   logic            start;

   assign start = (state == IDLE) && (i_request_select != dbg_pkg::SEL_NONE);

   // latch groups: selected word first, then its partner
   assign is_latch   = (sel_q >= dbg_pkg::SEL_FETCH_DATA) && (sel_q <= dbg_pkg::SEL_MEM_LAT_CTRL);
   assign sel_offset = sel_q - dbg_pkg::SEL_FETCH_DATA;
   assign stage      = sel_offset[2:1];
   assign pick_ctrl  = sel_offset[0] ^ word_cnt[0];
   assign last_word  = is_latch ? 2'd1 : 2'd0;

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         state    <= IDLE;
         sel_q    <= dbg_pkg::SEL_NONE;
         word_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  sel_q    <= i_request_select;
                  word_cnt <= '0;
                  // no data memory, finish at once
                  state    <= (i_request_select == dbg_pkg::SEL_MEM_DATA) ? DONE : SEND;
               end
            end
            SEND: begin
               if (word_cnt == last_word) begin
                  state <= DONE;
               end else begin
                  word_cnt <= word_cnt + 1'b1;
               end
            end
            DONE: state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clock) begin
      if (start) begin
         addr_q <= i_mem_addr[8:0];
      end
   end

   assign o_reg_sel   = sel_q[4:0];
   assign o_imem_addr = addr_q;
   assign o_eod       = (state == DONE);

   always_comb begin
      if (state != SEND) begin
         o_word = '0;
      end else if (is_latch) begin
         o_word = pick_ctrl ? i_latch_ctrl[stage] : i_latch_data[stage];
      end else if (sel_q == dbg_pkg::SEL_PC) begin
         o_word = i_pc;
      end else if (sel_q == dbg_pkg::SEL_MEM_INSTR) begin
         o_word = i_imem_rdata;
      end else begin
         o_word = i_reg_rdata;
      end
   end

endmodule

/* src/debug_interface.sv */
// debug interface: command decoder, execution-mode control, capture buffer, reply framer
`timescale 1ns/1ps

module debug_interface (
   input  logic            i_clock,
   input  logic            i_reset,
   input  dbg_pkg::frame_t i_frame_from_host,
   input  dbg_pkg::word_t  i_frame_from_target,
   input  logic            i_eod,
   input  logic            i_eop,
   output dbg_pkg::frame_t o_frame_to_host,
   output logic            o_valid,
   output logic            o_target_reset,
   output dbg_pkg::word_t  o_instr_data,
   output dbg_pkg::iaddr_t o_instr_addr,
   output logic [3:0]      o_instr_mem_we,
   output dbg_pkg::half_t  o_mem_addr,
   output dbg_pkg::sel_t   o_request_select
);

   dbg_pkg::cmd_t      cmd;
   logic [9:0]         addr_type;
   dbg_pkg::half_t     data_field;
   dbg_pkg::req_type_t req_type;
   logic               valid_q;
   logic               accept;
   logic               run;
   logic               step_mode;
   logic               capture_en;
   logic               capture_word;
   dbg_pkg::cnt_t      capture_cnt;
   dbg_pkg::cnt_t      reply_ptr;
   dbg_pkg::word_t     capture_buf [dbg_pkg::BUF_WORDS];
   dbg_pkg::sel_t      lookup_select;
   logic               data_ready;
   dbg_pkg::frame_t    reply;

   assign {cmd, addr_type, data_field} = i_frame_from_host;
   assign req_type = addr_type[8:0];

   // bit 9 of address/type is the host frame-valid flag
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= addr_type[9];
      end
   end

   assign accept = addr_type[9] & ~valid_q;

   // memory load path, data lands in the half selected by the command
   assign o_instr_addr = addr_type[8:0];
   assign o_instr_data = (cmd == dbg_pkg::CMD_LOAD_MSB) ? {data_field, 16'd0}
                                                         : {16'd0, data_field};
   assign o_mem_addr   = data_field;

   always_comb begin
      o_instr_mem_we = 4'b0000;
      if (accept && cmd == dbg_pkg::CMD_LOAD_LSB) begin
         o_instr_mem_we = 4'b0011;
      end else if (accept && cmd == dbg_pkg::CMD_LOAD_MSB) begin
         o_instr_mem_we = 4'b1100;
      end
   end

   assign o_target_reset = accept & (cmd == dbg_pkg::CMD_RESET);

   // execution mode, 1 means single step
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         step_mode <= 1'b0;
      end else if (accept && cmd == dbg_pkg::CMD_MODE_CONT) begin
         step_mode <= 1'b0;
      end else if (accept && cmd == dbg_pkg::CMD_MODE_STEP) begin
         step_mode <= 1'b1;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         run <= 1'b0;
      end else if (accept && cmd == dbg_pkg::CMD_START) begin
         run <= 1'b1;
      end
   end

   assign o_valid = step_mode ? (accept & run & (cmd == dbg_pkg::CMD_STEP)) : run;

   // request type to streamer select
   always_comb begin
      case (req_type)
         dbg_pkg::REQ_MEM_DATA:     lookup_select = dbg_pkg::SEL_MEM_DATA;
         dbg_pkg::REQ_MEM_INSTR:    lookup_select = dbg_pkg::SEL_MEM_INSTR;
         dbg_pkg::REQ_REG:          lookup_select = {1'b0, data_field[4:0]};
         dbg_pkg::REQ_REG_PC:       lookup_select = dbg_pkg::SEL_PC;
         dbg_pkg::REQ_FETCH_DATA:   lookup_select = dbg_pkg::SEL_FETCH_DATA;
         dbg_pkg::REQ_FETCH_CTRL:   lookup_select = dbg_pkg::SEL_FETCH_CTRL;
         dbg_pkg::REQ_DECO_DATA:    lookup_select = dbg_pkg::SEL_DECO_DATA;
         dbg_pkg::REQ_DECO_CTRL:    lookup_select = dbg_pkg::SEL_DECO_CTRL;
         dbg_pkg::REQ_EXEC_DATA:    lookup_select = dbg_pkg::SEL_EXEC_DATA;
         dbg_pkg::REQ_EXEC_CTRL:    lookup_select = dbg_pkg::SEL_EXEC_CTRL;
         dbg_pkg::REQ_MEM_LAT_DATA: lookup_select = dbg_pkg::SEL_MEM_LAT_DATA;
         dbg_pkg::REQ_MEM_LAT_CTRL: lookup_select = dbg_pkg::SEL_MEM_LAT_CTRL;
         default:                   lookup_select = dbg_pkg::SEL_NONE;
      endcase
   end

   // select only lives in the accept cycle
   assign o_request_select = (accept && cmd == dbg_pkg::CMD_REQ_DATA) ? lookup_select
                                                                       : dbg_pkg::SEL_NONE;

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         capture_en <= 1'b0;
      end else if (o_request_select != dbg_pkg::SEL_NONE) begin
         capture_en <= 1'b1;
      end else if (i_eod) begin
         capture_en <= 1'b0;
      end
   end

   assign capture_word = capture_en & ~i_eod & (capture_cnt < dbg_pkg::BUF_WORDS);

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         capture_cnt <= '0;
      end else if (accept && cmd == dbg_pkg::CMD_REQ_DATA) begin
         capture_cnt <= '0;
      end else if (capture_word) begin
         capture_cnt <= capture_cnt + 1'b1;
      end
   end

   always_ff @(posedge i_clock) begin
      if (capture_word) begin
         capture_buf[capture_cnt] <= i_frame_from_target;
      end
   end

   assign data_ready = reply_ptr < capture_cnt;

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         reply_ptr <= '0;
      end else if (accept && cmd == dbg_pkg::CMD_REQ_DATA) begin
         reply_ptr <= '0;
      end else if (accept && cmd == dbg_pkg::CMD_GIB_DATA && data_ready) begin
         reply_ptr <= reply_ptr + 1'b1;
      end
   end

   // reply priority: ok, nok, data, mode, end of program, idle
   always_comb begin
      if (cmd == dbg_pkg::CMD_GOT_DATA && data_ready) begin
         reply = dbg_pkg::FRAME_OK;
      end else if ((cmd == dbg_pkg::CMD_GOT_DATA || cmd == dbg_pkg::CMD_GIB_DATA) &&
                   !data_ready) begin
         reply = dbg_pkg::FRAME_NOK;
      end else if (cmd == dbg_pkg::CMD_GIB_DATA) begin
         reply = capture_buf[reply_ptr];
      end else if (cmd == dbg_pkg::CMD_MODE_GET) begin
         reply = step_mode ? dbg_pkg::FRAME_MODE_STEP : dbg_pkg::FRAME_MODE_CONT;
      end else if (i_eop) begin
         reply = dbg_pkg::FRAME_EOP;
      end else begin
         reply = dbg_pkg::FRAME_IDLE;
      end
   end

   // reply holds until the next accepted command
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_frame_to_host <= '0;
      end else if (accept) begin
         o_frame_to_host <= reply;
      end
   end

endmodule

/* src/debug_top.sv */
// debug port top level: interface, instruction memory, target core, readback streamer
`timescale 1ns/1ps

module debug_top (
   input  logic            i_clock,
   input  logic            i_reset,
   input  dbg_pkg::frame_t i_frame_from_host,
   output dbg_pkg::frame_t o_frame_to_host,
   output dbg_pkg::word_t  o_target_pc,
   output logic            o_target_reset
);

   logic            core_valid;
   logic [3:0]      instr_mem_we;
   dbg_pkg::iaddr_t instr_addr;
   dbg_pkg::word_t  instr_data;
   dbg_pkg::half_t  mem_addr;
   dbg_pkg::sel_t   request_select;
   dbg_pkg::word_t  stream_word;
   logic            eod;
   logic            eop;
   dbg_pkg::iaddr_t fetch_addr;
   dbg_pkg::iaddr_t stream_imem_addr;
   dbg_pkg::iaddr_t imem_raddr;
   dbg_pkg::word_t  imem_rdata;
   logic [4:0]      reg_sel;
   dbg_pkg::word_t  reg_rdata;
   dbg_pkg::word_t  latch_data [dbg_pkg::NB_STAGES];
   dbg_pkg::word_t  latch_ctrl [dbg_pkg::NB_STAGES];

   // shared read port, fetch wins a collision
   assign imem_raddr = core_valid ? fetch_addr : stream_imem_addr;

   debug_interface debug_interface_inst (
      .i_clock             (i_clock),
      .i_reset             (i_reset),
      .i_frame_from_host   (i_frame_from_host),
      .i_frame_from_target (stream_word),
      .i_eod               (eod),
      .i_eop               (eop),
      .o_frame_to_host     (o_frame_to_host),
      .o_valid             (core_valid),
      .o_target_reset      (o_target_reset),
      .o_instr_data        (instr_data),
      .o_instr_addr        (instr_addr),
      .o_instr_mem_we      (instr_mem_we),
      .o_mem_addr          (mem_addr),
      .o_request_select    (request_select)
   );

   instr_mem instr_mem_inst (
      .i_clock (i_clock),
      .i_we    (instr_mem_we),
      .i_waddr (instr_addr),
      .i_wdata (instr_data),
      .i_raddr (imem_raddr),
      .o_rdata (imem_rdata)
   );

   target_core target_core_inst (
      .i_clock        (i_clock),
      .i_reset        (i_reset),
      .i_target_reset (o_target_reset),
      .i_valid        (core_valid),
      .i_instr        (imem_rdata),
      .i_reg_sel      (reg_sel),
      .o_fetch_addr   (fetch_addr),
      .o_pc           (o_target_pc),
      .o_eop          (eop),
      .o_latch_data   (latch_data),
      .o_latch_ctrl   (latch_ctrl),
      .o_reg_rdata    (reg_rdata)
   );

   readback_streamer readback_streamer_inst (
      .i_clock          (i_clock),
      .i_reset          (i_reset),
      .i_request_select (request_select),
      .i_mem_addr       (mem_addr),
      .i_pc             (o_target_pc),
      .i_reg_rdata      (reg_rdata),
      .i_imem_rdata     (imem_rdata),
      .i_latch_data     (latch_data),
      .i_latch_ctrl     (latch_ctrl),
      .o_reg_sel        (reg_sel),
      .o_imem_addr      (stream_imem_addr),
      .o_word           (stream_word),
      .o_eod            (eod)
   );

endmodule

/* tests/debug_sva.sv */
// debug interface protocol assertions for select window, write lanes, reset pulse, run gate
`timescale 1ns/1ps

module debug_sva (
   input logic            i_clock,
   input logic            i_reset,
   input dbg_pkg::frame_t i_frame_from_host,
   input dbg_pkg::sel_t   i_request_select,
   input logic [3:0]      i_instr_mem_we,
   input logic            i_target_reset,
   input logic            i_valid
);

   dbg_pkg::cmd_t host_cmd;
   logic          flag_q;
   logic          host_accept;
   logic          started;
   int unsigned   failures = 0;

   // accept cycle as seen from the host frame
   assign host_cmd    = i_frame_from_host[31:26];
   assign host_accept = i_frame_from_host[25] & ~flag_q;

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         flag_q <= 1'b0;
      end else begin
         flag_q <= i_frame_from_host[25];
      end
   end

   // set once the host has sent START
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         started <= 1'b0;
      end else if (host_accept && host_cmd == dbg_pkg::CMD_START) begin
         started <= 1'b1;
      end
   end

   select_window: assert property (@(posedge i_clock) disable iff (i_reset)
      i_request_select != dbg_pkg::SEL_NONE |->
         host_accept && host_cmd == dbg_pkg::CMD_REQ_DATA)
      else begin
         failures++;
         $error("request select active outside a request accept cycle");
      end

   write_lanes: assert property (@(posedge i_clock) disable iff (i_reset)
      i_instr_mem_we != 4'b0000 |->
         host_accept &&
         ((host_cmd == dbg_pkg::CMD_LOAD_LSB && i_instr_mem_we == 4'b0011) ||
          (host_cmd == dbg_pkg::CMD_LOAD_MSB && i_instr_mem_we == 4'b1100)))
      else begin
         failures++;
         $error("instruction memory write lanes do not match an accepted load command");
      end

   reset_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
      i_target_reset |=> !i_target_reset)
      else begin
         failures++;
         $error("target reset held longer than one cycle");
      end

   run_gate: assert property (@(posedge i_clock) disable iff (i_reset)
      !started |-> !i_valid)
      else begin
         failures++;
         $error("target advanced before START");
      end

endmodule

bind debug_interface debug_sva debug_sva_inst (
   .i_clock           (i_clock),
   .i_reset           (i_reset),
   .i_frame_from_host (i_frame_from_host),
   .i_request_select  (o_request_select),
   .i_instr_mem_we    (o_instr_mem_we),
   .i_target_reset    (o_target_reset),
   .i_valid           (o_valid)
);

/* tests/debug_tb.sv */
// debug port testbench with host command tasks, readback and reply checks
`timescale 1ns/1ps

module debug_tb;

   localparam int N_WORDS    = 3;
   localparam int WAIT_LIMIT = 20;

   logic            clock = 1'b0;
   logic            reset;
   dbg_pkg::frame_t frame_from_host;
   dbg_pkg::frame_t frame_to_host;
   dbg_pkg::word_t  target_pc;
   logic            target_reset;

   int              seed = 32'h802d;
   int              errors = 0;
   int              checks = 0;
   int              reset_cycles = 0;
   int              pulses_before;
   dbg_pkg::word_t  words [N_WORDS];
   dbg_pkg::frame_t reply;

   debug_top debug_top_inst (
      .i_clock           (clock),
      .i_reset           (reset),
      .i_frame_from_host (frame_from_host),
      .o_frame_to_host   (frame_to_host),
      .o_target_pc       (target_pc),
      .o_target_reset    (target_reset)
   );

   always #5 clock = ~clock;

   // target reset cycles seen at the clock edge
   always @(posedge clock) begin
      if (target_reset) begin
         reset_cycles <= reset_cycles + 1;
      end
   end

   task automatic check_word(input string name, input dbg_pkg::word_t expected,
                             input dbg_pkg::word_t actual);
      checks++;
      assert (actual === expected) else begin
         $display("Error %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // fields settle before the valid flag rises
   task automatic send_cmd(input dbg_pkg::cmd_t cmd, input logic [8:0] addr,
                           input dbg_pkg::half_t data);
      frame_from_host = {cmd, 1'b0, addr, data};
      @(negedge clock);
      frame_from_host[25] = 1'b1;
      @(negedge clock);
      frame_from_host[25] = 1'b0;
      reply = frame_to_host;
   endtask

   task automatic load_word(input dbg_pkg::iaddr_t addr, input dbg_pkg::word_t word);
      send_cmd(dbg_pkg::CMD_LOAD_LSB, addr, word[15:0]);
      send_cmd(dbg_pkg::CMD_LOAD_MSB, addr, word[31:16]);
   endtask

   task automatic request_data(input dbg_pkg::req_type_t req, input dbg_pkg::half_t data);
      int cycles;
      cycles = 1;
      send_cmd(dbg_pkg::CMD_REQ_DATA, req, data);
      while (!debug_top_inst.eod && cycles < WAIT_LIMIT) begin
         @(negedge clock);
         cycles++;
      end
      if (!debug_top_inst.eod) begin
         $display("Timeout: burst for request type %h never ended", req);
         errors++;
      end
      // at least four cycles between request and read
      while (cycles < 4) begin
         @(negedge clock);
         cycles++;
      end
   endtask

   task automatic read_burst(input string name, input dbg_pkg::req_type_t req,
                             input dbg_pkg::half_t data, input dbg_pkg::word_t expected);
      request_data(req, data);
      send_cmd(dbg_pkg::CMD_GIB_DATA, '0, '0);
      check_word(name, expected, reply);
   endtask

   initial begin
      reset = 1'b1;
      frame_from_host = '0;
      for (int k = 0; k < N_WORDS; k++) begin
         words[k] = $random(seed);
      end
      repeat (4) @(negedge clock);
      reset = 1'b0;
      check_word("reset_reply", '0, frame_to_host);
      check_word("reset_pc", '0, target_pc);

      // load in halves and read back through the streamer
      for (int k = 0; k < N_WORDS; k++) begin
         load_word(dbg_pkg::iaddr_t'(k), words[k]);
      end
      for (int k = 0; k < N_WORDS; k++) begin
         read_burst("mem_instr", dbg_pkg::REQ_MEM_INSTR, dbg_pkg::half_t'(k), words[k]);
      end

      send_cmd(dbg_pkg::CMD_MODE_STEP, '0, '0);
      send_cmd(dbg_pkg::CMD_MODE_GET, '0, '0);
      check_word("mode_step", dbg_pkg::FRAME_MODE_STEP, reply);
      send_cmd(dbg_pkg::CMD_MODE_CONT, '0, '0);
      send_cmd(dbg_pkg::CMD_MODE_GET, '0, '0);
      check_word("mode_cont", dbg_pkg::FRAME_MODE_CONT, reply);

      // single step through the loaded words
      send_cmd(dbg_pkg::CMD_MODE_STEP, '0, '0);
      send_cmd(dbg_pkg::CMD_START, '0, '0);
      check_word("start_pc", '0, target_pc);
      for (int k = 0; k < N_WORDS; k++) begin
         send_cmd(dbg_pkg::CMD_STEP, '0, '0);
      end
      check_word("step_pc", N_WORDS, target_pc);
      read_burst("reg_pc", dbg_pkg::REQ_REG_PC, '0, N_WORDS);

      for (int k = 0; k < N_WORDS; k++) begin
         read_burst("reg", dbg_pkg::REQ_REG, dbg_pkg::half_t'(k), words[k]);
      end
      read_burst("fetch_data", dbg_pkg::REQ_FETCH_DATA, '0, words[N_WORDS-1]);
      send_cmd(dbg_pkg::CMD_GIB_DATA, '0, '0);
      check_word("fetch_ctrl", N_WORDS - 1, reply);
      read_burst("deco_data", dbg_pkg::REQ_DECO_DATA, '0, words[N_WORDS-2]);
      send_cmd(dbg_pkg::CMD_GIB_DATA, '0, '0);
      check_word("deco_ctrl", N_WORDS - 2, reply);

      // buffer status replies
      request_data(dbg_pkg::REQ_REG_PC, '0);
      send_cmd(dbg_pkg::CMD_GOT_DATA, '0, '0);
      check_word("got_ok", dbg_pkg::FRAME_OK, reply);
      send_cmd(dbg_pkg::CMD_GIB_DATA, '0, '0);
      check_word("gib_word", N_WORDS, reply);
      send_cmd(dbg_pkg::CMD_GOT_DATA, '0, '0);
      check_word("got_nok", dbg_pkg::FRAME_NOK, reply);
      send_cmd(dbg_pkg::CMD_GIB_DATA, '0, '0);
      check_word("gib_nok", dbg_pkg::FRAME_NOK, reply);
      request_data(dbg_pkg::REQ_MEM_DATA, '0);
      send_cmd(dbg_pkg::CMD_GOT_DATA, '0, '0);
      check_word("mem_data_nok", dbg_pkg::FRAME_NOK, reply);

      pulses_before = reset_cycles;
      send_cmd(dbg_pkg::CMD_RESET, '0, '0);
      @(negedge clock);
      check_word("reset_pulse", 32'd1, dbg_pkg::word_t'(reset_cycles - pulses_before));
      check_word("target_reset_pc", '0, target_pc);

      // protocol assertion failures from the bound checker
      errors += debug_top_inst.debug_interface_inst.debug_sva_inst.failures;

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
src/dbg_pkg.sv
src/instr_mem.sv
src/target_core.sv
src/readback_streamer.sv
src/debug_interface.sv
src/debug_top.sv
tests/debug_sva.sv
tests/debug_tb.sv

/* Makefile */
# Verilator simulation of the debug port testbench

VERILATOR ?= verilator
TOP       ?= debug_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
